// ==== include/board_defs.svh ====
// Board identifiers, APB address width, debounce timing and register offsets
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Fixed identification words
`define FPGA_ID_VAL      32'hC341_A0DD
`define FW_VER_VAL       32'h0000_0100
`define BOARD_ID_VAL     32'h1172_B00A

// APB byte address width
`define APB_ADDR_W       8

// Debounce sampling, in pcie_clk cycles between samples
`define DEBOUNCE_RATE    16
// Consecutive equal samples before the output follows
`define DEBOUNCE_SAMPLES 4

// Register byte offsets
`define REG_FPGA_ID      8'h00
`define REG_FW_VER       8'h04
`define REG_BOARD_ID     8'h08
`define REG_GPIO_IN      8'h0C
`define REG_LED          8'h10
`define REG_QSFP_CTRL    8'h14
`define REG_QSFP_STAT    8'h18
`define REG_I2C          8'h1C

`endif

// ==== rtl/board_pkg.sv ====
// APB request and response, QSFP-DD cage pin, control and I2C drive, and LED types
`include "board_defs.svh"

package board_pkg;

    // APB master to slave
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Cage control outputs, initmode sits in the top bit
    typedef struct packed {
        logic initmode;
        logic mod_sel_n;
        logic rst_n;
    } qsfp_ctrl_t;

    // Cage sideband inputs, raw or synchronized
    typedef struct packed {
        logic interrupt_n;
        logic mod_prs_n;
        logic scl;
        logic sda;
    } qsfp_pins_t;

    // Open-drain enables, set means pull low
    typedef struct packed {
        logic scl_oe;
        logic sda_oe;
    } i2c_drive_t;

    // Board LEDs in the low nibble, bracket LEDs above
    typedef struct packed {
        logic [3:0] led_bracket;
        logic [3:0] led;
    } led_t;

endpackage

// ==== rtl/switch_debounce.sv ====
// Two-flop synchronizer and sampled debounce filter for buttons and switches
`include "board_defs.svh"

module switch_debounce (
    input  logic       pcie_clk,
    input  logic       arst_n_i,
    input  logic [3:0] raw_i,
    output logic [3:0] state_o
);

    localparam int N_IN    = 4;
    localparam int RATE    = `DEBOUNCE_RATE;
    localparam int SAMPLES = `DEBOUNCE_SAMPLES;
    localparam int CNT_W   = $clog2(RATE);

    logic [N_IN-1:0]              sync_meta;
    logic [N_IN-1:0]              sync_q;
    logic [CNT_W-1:0]             rate_cnt;
    logic                         tick;
    logic                         tick_q;
    logic [N_IN-1:0][SAMPLES-1:0] hist;

    assign tick = (rate_cnt == CNT_W'(RATE - 1));

    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_meta <= '0;
            sync_q    <= '0;
            rate_cnt  <= '0;
            tick_q    <= 1'b0;
        end else begin
            sync_meta <= raw_i;
            sync_q    <= sync_meta;
            rate_cnt  <= tick ? '0 : rate_cnt + 1'b1;
            tick_q    <= tick;
        end
    end

    // History shifts on the tick, output settles one cycle later
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist    <= '0;
            state_o <= '0;
        end else begin
            for (int i = 0; i < N_IN; i++) begin
                if (tick) begin
                    hist[i] <= {hist[i][SAMPLES-2:0], sync_q[i]};
                end
                if (tick_q && (&hist[i])) begin
                    state_o[i] <= 1'b1;
                end else if (tick_q && !(|hist[i])) begin
                    state_o[i] <= 1'b0;
                end
            end
        end
    end

    // Counter has just wrapped in the cycle after a tick
    a_state_after_tick: assert property (
        @(posedge pcie_clk) disable iff (!arst_n_i)
        (state_o != $past(state_o)) |-> ($past(rate_cnt) == '0)
    ) else $error("debounced state moved outside a sample slot");

endmodule

// ==== rtl/qsfpdd_pin_io.sv ====
// QSFP-DD sideband input synchronizer and registered I2C open-drain enables
module qsfpdd_pin_io
    import board_pkg::*;
(
    input  logic                  pcie_clk,
    input  logic                  arst_n_i,
    input  qsfp_pins_t [1:0]      pins_i,
    output qsfp_pins_t [1:0]      pins_sync_o,
    input  i2c_drive_t [1:0]      drive_req_i,
    output i2c_drive_t [1:0]      drive_o
);

    // First stage of the pin synchronizer
    qsfp_pins_t [1:0] pins_meta;

    // All eight sideband inputs of both cages, two flops deep
    always_ff @(posedge pcie_clk) begin
        pins_meta   <= pins_i;
        pins_sync_o <= pins_meta;
    end

    // Drive enables go out through a flop, released in reset
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drive_o <= '0;
        end else begin
            drive_o <= drive_req_i;
        end
    end

    // Pins must never see an undefined pull-down
    a_drive_known: assert property (
        @(posedge pcie_clk) disable iff (!arst_n_i)
        !$isunknown(drive_o)
    ) else $error("I2C drive enable is unknown");

endmodule

// ==== rtl/board_ctrl_regs.sv ====
// APB register file for identifiers, GPIO, LEDs, cage control and status, I2C bit-bang
`include "board_defs.svh"

module board_ctrl_regs
    import board_pkg::*;
(
    input  logic                  pcie_clk,
    input  logic                  arst_n_i,
    input  apb_req_t              apb_i,
    output apb_rsp_t              apb_o,
    input  logic [3:0]            gpio_i,
    input  qsfp_pins_t [1:0]      pins_i,
    output led_t                  leds_o,
    output qsfp_ctrl_t [1:0]      qsfp_ctrl_o,
    output i2c_drive_t [1:0]      drive_req_o
);

    logic        setup;
    logic        wr_en;
    logic        hit;
    logic        read_only;
    logic        err;
    logic [31:0] rd_data;

    // Setup phase of an access, response is registered here
    assign setup = apb_i.psel && !apb_i.penable;

    // Completing write that passed decode in setup
    assign wr_en = apb_i.psel && apb_i.penable && apb_i.pwrite &&
                   apb_o.pready && !apb_o.pslverr;

    // Offset decode and read mux
    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (apb_i.paddr)
            `REG_FPGA_ID: begin
                read_only = 1'b1;
                rd_data   = `FPGA_ID_VAL;
            end
            `REG_FW_VER: begin
                read_only = 1'b1;
                rd_data   = `FW_VER_VAL;
            end
            `REG_BOARD_ID: begin
                read_only = 1'b1;
                rd_data   = `BOARD_ID_VAL;
            end
            `REG_GPIO_IN: begin
                read_only = 1'b1;
                rd_data   = {28'd0, gpio_i};
            end
            `REG_LED: begin
                rd_data = {24'd0, leds_o};
            end
            `REG_QSFP_CTRL: begin
                rd_data = {25'd0, qsfp_ctrl_o[1], 1'b0, qsfp_ctrl_o[0]};
            end
            `REG_QSFP_STAT: begin
                read_only = 1'b1;
                rd_data   = {26'd0,
                             pins_i[1].interrupt_n, pins_i[1].mod_prs_n, 2'b00,
                             pins_i[0].interrupt_n, pins_i[0].mod_prs_n};
            end
            `REG_I2C: begin
                // Drive bits low, pin readback in the second byte
                rd_data = {18'd0,
                           pins_i[1].scl, pins_i[1].sda, 2'b00,
                           pins_i[0].scl, pins_i[0].sda, 2'b00,
                           drive_req_o[1], 2'b00, drive_req_o[0]};
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    assign err = !hit || (apb_i.pwrite && read_only);

    // One-cycle response, valid through the access phase
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            apb_o <= '0;
        end else begin
            apb_o.pready  <= setup;
            apb_o.pslverr <= setup && err;
            apb_o.prdata  <= (setup && !err && !apb_i.pwrite) ? rd_data : '0;
        end
    end

    // Writable registers
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            leds_o      <= '0;
            qsfp_ctrl_o <= '0;
            drive_req_o <= '0;
        end else if (wr_en) begin
            case (apb_i.paddr)
                `REG_LED: begin
                    leds_o <= apb_i.pwdata[7:0];
                end
                `REG_QSFP_CTRL: begin
                    qsfp_ctrl_o[0] <= apb_i.pwdata[2:0];
                    qsfp_ctrl_o[1] <= apb_i.pwdata[6:4];
                end
                `REG_I2C: begin
                    drive_req_o[0] <= apb_i.pwdata[1:0];
                    drive_req_o[1] <= apb_i.pwdata[5:4];
                end
                default: begin
                end
            endcase
        end
    end

    a_penable_psel: assert property (
        @(posedge pcie_clk) disable iff (!arst_n_i)
        apb_i.penable |-> apb_i.psel
    ) else $error("APB penable without psel");

    // Error response only while the master is in the access phase
    a_err_ready: assert property (
        @(posedge pcie_clk) disable iff (!arst_n_i)
        apb_o.pslverr |-> (apb_o.pready && apb_i.psel && apb_i.penable)
    ) else $error("APB pslverr outside an access phase");

endmodule

// ==== rtl/board_mgmt_top.sv ====
// Board management top level with debounce, cage pin and register file blocks
`include "board_defs.svh"

module board_mgmt_top
    import board_pkg::*;
(
    input  logic                  pcie_clk,
    input  logic                  arst_n_i,

    // Register access
    input  apb_req_t              apb_i,
    output apb_rsp_t              apb_o,

    // Raw user inputs
    input  logic [1:0]            button_i,
    input  logic [1:0]            sw_i,

    // Cages, index 0 is A and 1 is B
    input  qsfp_pins_t [1:0]      qsfp_pins_i,
    output qsfp_ctrl_t [1:0]      qsfp_ctrl_o,
    output i2c_drive_t [1:0]      i2c_drive_o,

    output led_t                  leds_o
);

    logic [3:0]       gpio_state;
    qsfp_pins_t [1:0] pins_sync;
    i2c_drive_t [1:0] drive_req;

    // Buttons in the low bits, switches above
    switch_debounce debounce_inst (
        .pcie_clk    (pcie_clk),
        .arst_n_i    (arst_n_i),
        .raw_i       ({sw_i, button_i}),
        .state_o     (gpio_state)
    );

    qsfpdd_pin_io pin_io_inst (
        .pcie_clk    (pcie_clk),
        .arst_n_i    (arst_n_i),
        .pins_i      (qsfp_pins_i),
        .pins_sync_o (pins_sync),
        .drive_req_i (drive_req),
        .drive_o     (i2c_drive_o)
    );

    board_ctrl_regs regs_inst (
        .pcie_clk    (pcie_clk),
        .arst_n_i    (arst_n_i),
        .apb_i       (apb_i),
        .apb_o       (apb_o),
        .gpio_i      (gpio_state),
        .pins_i      (pins_sync),
        .leds_o      (leds_o),
        .qsfp_ctrl_o (qsfp_ctrl_o),
        .drive_req_o (drive_req)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
// Bench pcie_clk generator and power-on reset
module tb_clk_gen (
    output logic pcie_clk,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_NS    = 4;
    localparam int RST_CYCLES = 5;

    initial begin
        pcie_clk = 1'b0;
        forever #(HALF_NS) pcie_clk = ~pcie_clk;
    end

    // Reset released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(negedge pcie_clk);
        arst_n_o = 1'b1;
    end

endmodule

// ==== bench/tb_checker.sv ====
// Bench checker with register model, APB response checks and output comparison
`include "board_defs.svh"

module tb_checker
    import board_pkg::*;
(
    input  logic             pcie_clk,
    input  logic             arst_n_i,
    input  apb_req_t         apb_req_i,
    input  apb_rsp_t         apb_rsp_i,
    input  logic [1:0]       button_i,
    input  logic [1:0]       sw_i,
    input  qsfp_pins_t [1:0] pins_i,
    input  qsfp_ctrl_t [1:0] qsfp_ctrl_i,
    input  i2c_drive_t [1:0] drive_i,
    input  led_t             leds_i,
    output int               err_cnt_o,
    output int               chk_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Longest debounce latency once the raw input holds still
    localparam int SETTLE = (`DEBOUNCE_SAMPLES + 1) * `DEBOUNCE_RATE + 2;

    led_t             m_led;
    qsfp_ctrl_t [1:0] m_ctrl;
    i2c_drive_t [1:0] m_drive;
    i2c_drive_t [1:0] m_drive_q;
    logic [3:0]       m_gpio;
    logic [3:0]       raw_q;
    int               stable_cnt;
    int               errs = 0;
    int               checks = 0;

    assign err_cnt_o = errs;
    assign chk_cnt_o = checks;

    task automatic flag_mismatch(input string msg);
        errs++;
        $display("[ERROR] t=%0t: %s", $time, msg);
    endtask

    function automatic logic is_mapped(input logic [`APB_ADDR_W-1:0] addr);
        return (addr <= `REG_I2C) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic is_read_only(input logic [`APB_ADDR_W-1:0] addr);
        return addr inside {`REG_FPGA_ID, `REG_FW_VER, `REG_BOARD_ID,
                            `REG_GPIO_IN, `REG_QSFP_STAT};
    endfunction

    // Register layout as seen by software
    function automatic logic [31:0] expected_read(input logic [`APB_ADDR_W-1:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            `REG_FPGA_ID:  v = `FPGA_ID_VAL;
            `REG_FW_VER:   v = `FW_VER_VAL;
            `REG_BOARD_ID: v = `BOARD_ID_VAL;
            `REG_GPIO_IN:  v[3:0] = m_gpio;
            `REG_LED:      v[7:0] = m_led;
            `REG_QSFP_CTRL: begin
                v[2:0] = m_ctrl[0];
                v[6:4] = m_ctrl[1];
            end
            `REG_QSFP_STAT: begin
                v[1:0] = {pins_i[0].interrupt_n, pins_i[0].mod_prs_n};
                v[5:4] = {pins_i[1].interrupt_n, pins_i[1].mod_prs_n};
            end
            `REG_I2C: begin
                v[1:0]   = m_drive[0];
                v[5:4]   = m_drive[1];
                v[9:8]   = {pins_i[0].scl, pins_i[0].sda};
                v[13:12] = {pins_i[1].scl, pins_i[1].sda};
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic check_completion();
        logic [`APB_ADDR_W-1:0] addr;
        logic [31:0]            want;
        logic                   bad;
        addr = apb_req_i.paddr;
        bad  = !is_mapped(addr) || (apb_req_i.pwrite && is_read_only(addr));
        want = bad ? 32'd0 : expected_read(addr);
        checks++;
        if (bad != apb_rsp_i.pslverr) begin
            flag_mismatch($sformatf("pslverr %0b at offset 0x%02h, expected %0b",
                                    apb_rsp_i.pslverr, addr, bad));
        end else if (bad || !apb_req_i.pwrite) begin
            if (apb_rsp_i.prdata != want) begin
                flag_mismatch($sformatf("prdata 0x%08h at offset 0x%02h, expected 0x%08h",
                                        apb_rsp_i.prdata, addr, want));
            end
        end else begin
            case (addr)
                `REG_LED: m_led = apb_req_i.pwdata[7:0];
                `REG_QSFP_CTRL: begin
                    m_ctrl[0] = apb_req_i.pwdata[2:0];
                    m_ctrl[1] = apb_req_i.pwdata[6:4];
                end
                `REG_I2C: begin
                    m_drive[0] = apb_req_i.pwdata[1:0];
                    m_drive[1] = apb_req_i.pwdata[5:4];
                end
                default: m_led = m_led;
            endcase
        end
    endtask

    always @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_led      = '0;
            m_ctrl     = '0;
            m_drive    = '0;
            m_drive_q  = '0;
            m_gpio     = '0;
            raw_q      = '0;
            stable_cnt = 0;
        end else begin
            // Outputs hold what the previous edge produced
            checks++;
            if (leds_i != m_led) begin
                flag_mismatch($sformatf("leds 0x%02h, expected 0x%02h", leds_i, m_led));
            end
            if (qsfp_ctrl_i != m_ctrl) begin
                flag_mismatch($sformatf("cage control 0x%02h, expected 0x%02h",
                                        qsfp_ctrl_i, m_ctrl));
            end
            if (drive_i != m_drive_q) begin
                flag_mismatch($sformatf("I2C drive 0x%01h, expected 0x%01h", drive_i, m_drive_q));
            end
            // Drive pins trail the register by one edge
            m_drive_q = m_drive;
            if ({sw_i, button_i} != raw_q) begin
                raw_q      = {sw_i, button_i};
                stable_cnt = 0;
            end else if (stable_cnt < SETTLE) begin
                stable_cnt++;
            end else begin
                m_gpio = raw_q;
            end
            if (apb_rsp_i.pready && !(apb_req_i.psel && apb_req_i.penable)) begin
                flag_mismatch("pready high outside an access phase");
            end
            if (apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready) begin
                check_completion();
            end
        end
    end

endmodule

// ==== bench/tb_top.sv ====
// Bench top with DUT, LFSR stimulus, APB master, test sequence and watchdog
`include "board_defs.svh"

module tb_top
    import board_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS    = 8;
    localparam int N_XFER    = 177;
    localparam int N_DEB     = 16;
    localparam int WD_CYCLES = N_XFER * 4 + N_DEB * 120;
    localparam int DEB_HOLD  = (`DEBOUNCE_SAMPLES + 2) * `DEBOUNCE_RATE;
    localparam int XFER_MAX  = 8;

    logic             pcie_clk;
    logic             arst_n;
    apb_req_t         apb_req;
    apb_rsp_t         apb_rsp;
    logic [1:0]       button;
    logic [1:0]       sw;
    qsfp_pins_t [1:0] pins;
    qsfp_ctrl_t [1:0] qsfp_ctrl;
    i2c_drive_t [1:0] i2c_drive;
    led_t             leds;
    int               err_cnt;
    int               chk_cnt;
    int               hang_cnt;
    int               err_mark;
    int               test_num;
    logic [15:0]      lfsr_state;

    tb_clk_gen clk_gen_inst (.pcie_clk(pcie_clk), .arst_n_o(arst_n));

    board_mgmt_top dut_i (
        .pcie_clk    (pcie_clk),
        .arst_n_i    (arst_n),
        .apb_i       (apb_req),
        .apb_o       (apb_rsp),
        .button_i    (button),
        .sw_i        (sw),
        .qsfp_pins_i (pins),
        .qsfp_ctrl_o (qsfp_ctrl),
        .i2c_drive_o (i2c_drive),
        .leds_o      (leds)
    );

    tb_checker checker_inst (
        .pcie_clk    (pcie_clk),
        .arst_n_i    (arst_n),
        .apb_req_i   (apb_req),
        .apb_rsp_i   (apb_rsp),
        .button_i    (button),
        .sw_i        (sw),
        .pins_i      (pins),
        .qsfp_ctrl_i (qsfp_ctrl),
        .drive_i     (i2c_drive),
        .leds_i      (leds),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [7:0] ro_offset(input int k);
        case (k)
            0:       return `REG_FPGA_ID;
            1:       return `REG_FW_VER;
            2:       return `REG_BOARD_ID;
            3:       return `REG_GPIO_IN;
            default: return `REG_QSFP_STAT;
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge pcie_clk);
    endtask

    // Starts and ends just after a falling edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        int waited;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge pcie_clk);
        apb_req.penable = 1'b1;
        waited = 0;
        do begin
            @(posedge pcie_clk);
            waited++;
        end while (!apb_rsp.pready && waited < XFER_MAX);
        if (!apb_rsp.pready) begin
            hang_cnt++;
            $display("APB transfer to offset 0x%02h was never answered with pready", addr);
        end
        @(negedge pcie_clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic end_test(input string name);
        int errs;
        idle(2);
        test_num++;
        errs     = err_cnt + hang_cnt - err_mark;
        err_mark = err_cnt + hang_cnt;
        $display("[test %0d] %s finished with %0d errors", test_num, name, errs);
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  a;
        apb_req    = '0;
        button     = '0;
        sw         = '0;
        pins       = {2{4'b1011}};
        lfsr_state = 16'd5194;
        hang_cnt   = 0;
        err_mark   = 0;
        test_num   = 0;
        @(posedge arst_n);
        @(negedge pcie_clk);

        apb_xfer(1'b0, `REG_FPGA_ID, '0);
        apb_xfer(1'b0, `REG_FW_VER, '0);
        apb_xfer(1'b0, `REG_BOARD_ID, '0);
        apb_xfer(1'b0, `REG_LED, '0);
        apb_xfer(1'b0, `REG_QSFP_CTRL, '0);
        apb_xfer(1'b0, `REG_I2C, '0);
        end_test("reset values");

        repeat (16) begin
            apb_xfer(1'b1, `REG_LED, rand_bits(32));
            apb_xfer(1'b1, `REG_QSFP_CTRL, rand_bits(32));
            apb_xfer(1'b0, `REG_LED, '0);
            apb_xfer(1'b0, `REG_QSFP_CTRL, '0);
        end
        end_test("LED and cage control");

        repeat (16) begin
            apb_xfer(1'b1, `REG_I2C, rand_bits(32));
            r = rand_bits(4);
            {pins[0].scl, pins[0].sda, pins[1].scl, pins[1].sda} = r[3:0];
            idle(4);
            apb_xfer(1'b0, `REG_I2C, '0);
        end
        end_test("I2C drive and readback");

        repeat (16) begin
            r = rand_bits(4);
            {pins[0].interrupt_n, pins[0].mod_prs_n} = r[1:0];
            {pins[1].interrupt_n, pins[1].mod_prs_n} = r[3:2];
            idle(4);
            apb_xfer(1'b0, `REG_QSFP_STAT, '0);
        end
        end_test("cage status");

        repeat (8) begin
            r = rand_bits(4);
            {sw, button} = r[3:0];
            idle(DEB_HOLD);
            apb_xfer(1'b0, `REG_GPIO_IN, '0);
        end
        // One bit flips for less than a sample period, read during and after it
        repeat (8) begin
            r = rand_bits(6);
            {sw, button} = {sw, button} ^ (4'b0001 << r[1:0]);
            idle(r[5:2] % 11 + 3);
            apb_xfer(1'b0, `REG_GPIO_IN, '0);
            {sw, button} = {sw, button} ^ (4'b0001 << r[1:0]);
            idle(2 * `DEBOUNCE_RATE);
            apb_xfer(1'b0, `REG_GPIO_IN, '0);
        end
        end_test("buttons and switches");

        repeat (16) begin
            r = rand_bits(9);
            a = r[7:0];
            if (a <= `REG_I2C && a[1:0] == 2'b00) begin
                a[0] = 1'b1;
            end
            apb_xfer(r[8], a, rand_bits(32));
            r = rand_bits(3);
            apb_xfer(1'b1, ro_offset(r[2:0] % 5), rand_bits(32));
        end
        apb_xfer(1'b0, `REG_LED, '0);
        apb_xfer(1'b0, `REG_QSFP_CTRL, '0);
        apb_xfer(1'b0, `REG_I2C, '0);
        end_test("error responses");

        $display("checks: %0d, errors: %0d, hung transfers: %0d", chk_cnt, err_cnt, hang_cnt);
        if (err_cnt == 0 && hang_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Budget of four cycles per transfer and 120 per debounce wait
    initial begin
        #(WD_CYCLES * CLK_NS);
        $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/board_pkg.sv
rtl/switch_debounce.sv
rtl/qsfpdd_pin_io.sv
rtl/board_ctrl_regs.sv
rtl/board_mgmt_top.sv
bench/tb_clk_gen.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
